// ==== build.f ====
common/adxl_frame_pkg.sv
common/adxl_tag_pkg.sv
common/spi_frame_if.sv
adxl_reader/adxl_seq_fsm.sv
adxl_reader/adxl_bit_timer.sv
adxl_reader/tag_fifo.sv
adxl_reader/adxl_spi_shifter.sv
adxl_reader/chan1_replay_buf.sv
design/adxl_reader_top.sv
dv/tb_clk_gen.sv
dv/tb_adxl_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the frame reader testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_adxl_reader -f build.f

./obj_dir/Vtb_adxl_reader > sim.log 2>&1
cat sim.log

if grep -q "All checks passed" sim.log
then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi

// ==== dv/tb_adxl_reader.sv ====
// Testbench for the dual ADXL355 frame reader with two SPI slave models
// a row table sets cmd, len and tag stimulus, expected writes follow the frame rules
`timescale 1ns/1ps

module tb_adxl_reader;

  localparam int n_rows     = 5;
  localparam int max_cycles = n_rows * 1500; // longest frame stays well below 1500 clks

  typedef struct packed {
    logic [7:0]  cmd;
    logic [3:0]  len;
    logic [1:0]  n_push; // tag chars pushed before sync
    logic [11:0] push;   // first char in [5:0]
    logic        pulse;  // tag_pulse before sync
  } row_t;

  typedef struct packed {
    logic [7:0] data;
    logic       w16;
    logic       xx;
    logic       consec; // replay write, must follow a write cycle
  } wr_t;

  row_t rows [n_rows] = '{
    '{8'h0b, 4'd10, 2'd0, 12'h000, 1'b0},         // empty FIFO, space char
    '{8'h11, 4'd9,  2'd2, {6'h2a, 6'h15}, 1'b0},  // pops 0x15
    '{8'h0b, 4'd12, 2'd0, 12'h000, 1'b1},         // pulse wins, 0x2a stays queued
    '{8'h4c, 4'd15, 2'd1, {6'h00, 6'h07}, 1'b0},  // pops 0x2a, longest frame
    '{8'h0e, 4'd11, 2'd0, 12'h000, 1'b0}          // pops 0x07
  };

  logic         clk;
  logic         rst_n;
  logic         clk_en = 1'b0;
  logic         sclk_phase, sclk_polarity, direct, tag_pulse, tag_en, sync;
  logic [5:0]   tag;
  logic [7:0]   cmd;
  logic [3:0]   len;
  logic         direct_en, adxl_mosi, adxl_sclk, adxl_csn, adxl0_miso, adxl1_miso;
  logic [7:0]   wrdata;
  logic         wr, wr16, x;
  logic [7:0]   cmd_rx0, cmd_rx1;  // command seen by each slave
  logic [127:0] tx0, tx1;          // slave streams, first byte in the top bits
  logic         last_wr = 1'b0;
  wr_t          exp_q [$];         // expected write cycles in order
  logic [5:0]   tag_model [$];     // mirror of the tag FIFO
  int           en_cnt, cycles, errors, n_tests, n_bad, r;

  tb_clk_gen clk_gen (.clk, .rst_n);

  adxl_reader_top UUT (.*);

  spi_slave_model slave0 (.clk, .sclk(adxl_sclk), .csn(adxl_csn), .mosi(adxl_mosi),
                          .tx_bits(tx0), .miso(adxl0_miso), .cmd_rx(cmd_rx0));
  spi_slave_model slave1 (.clk, .sclk(adxl_sclk), .csn(adxl_csn), .mosi(adxl_mosi),
                          .tx_bits(tx1), .miso(adxl1_miso), .cmd_rx(cmd_rx1));

  task automatic show_mismatch(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
    $display("FAILED t=%0t %s: got %02h, expected %02h", $time, name, got, expected);
    errors++;
  endtask

  task automatic log_fault(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  // channel 0 live writes, then six channel 1 replay writes
  task automatic build_expected(input int n_len, input logic [5:0] tch);
    logic [7:0] b0, b1;
    logic [7:0] kept [$];
    logic       keep16;
    int         d, j, step;
    wr_t        e;
    j = 0;
    for (d = 0; d <= n_len - 2; d++)
    begin
      step   = 18 + 8 * d;                       // half-index where data byte d completes
      keep16 = step != 34 && step != 58 && step != 82;
      b0     = tx0[127 - 8 * d -: 8];
      b1     = tx1[127 - 8 * d -: 8];
      if (keep16)
      begin
        if (j % 2 == 1 && j <= 5)                // odd wr16 bytes carry the tag bits
        begin
          b0[0] = tch[(j - 1) / 2];
          b1[0] = tch[3 + (j - 1) / 2];
        end
        if (j < 6)
          kept.push_back(b1);
        j++;
      end
      e.data   = b0;
      e.w16    = keep16;
      e.xx     = d == 0;
      e.consec = 1'b0;
      exp_q.push_back(e);
    end
    for (d = 0; d < kept.size(); d++)
    begin
      e.data   = kept[d];
      e.w16    = 1'b1;
      e.xx     = 1'b0;
      e.consec = d != 0;                         // replay runs back to back
      exp_q.push_back(e);
    end
  endtask

  task automatic check_write();
    wr_t e;
    if (!wr)
      log_fault("wr16 or x pulsed without wr");
    else if (exp_q.size() == 0)
      log_fault($sformatf("unexpected write of %02h", wrdata));
    else
    begin
      e = exp_q.pop_front();
      if (wrdata !== e.data)
        show_mismatch("wrdata", wrdata, e.data);
      if (wr16 !== e.w16)
        show_mismatch("wr16", 8'(wr16), 8'(e.w16));
      if (x !== e.xx)
        show_mismatch("x", 8'(x), 8'(e.xx));
      if (e.consec && !last_wr)
        log_fault("channel 1 replay write not back to back");
    end
  endtask

  task automatic run_frame(input int idx, input logic grab);
    row_t       row;
    logic [5:0] tch;
    int         err0, k;
    row  = rows[idx];
    err0 = errors;
    tx0  = {$urandom, $urandom, $urandom, $urandom};
    tx1  = {$urandom, $urandom, $urandom, $urandom};
    for (k = 0; k < row.n_push; k++)
    begin
      tag    = row.push[6 * k +: 6];
      tag_en = 1'b1;
      tag_model.push_back(tag);
      @(negedge clk);
    end
    tag_en    = 1'b0;
    tag_pulse = row.pulse;
    @(negedge clk);
    tag_pulse = 1'b0;
    repeat (2) @(negedge clk);                   // FIFO head read is registered
    if (row.pulse)
      tch = 6'h21;
    else if (tag_model.size() == 0)
      tch = 6'h20;
    else
      tch = tag_model.pop_front();
    build_expected(int'(row.len), tch);
    cmd  = row.cmd;
    len  = row.len;
    sync = 1'b1;
    @(negedge clk);
    sync = 1'b0;
    while (adxl_csn)
      @(negedge clk);                            // frame running
    if (grab)
      direct = 1'b1;                             // grant requested mid-frame, held until the end
    while (!adxl_csn)
      @(negedge clk);                            // csn rise ends the frame
    for (k = 0; k < 20 && exp_q.size() != 0; k++)
      @(posedge clk);                            // replay drains right after the end
    @(negedge clk);
    if (exp_q.size() != 0)
      log_fault($sformatf("%0d expected writes never appeared", exp_q.size()));
    exp_q.delete();
    if (cmd_rx0 !== row.cmd)
      show_mismatch("slave0 cmd", cmd_rx0, row.cmd);
    if (cmd_rx1 !== row.cmd)
      show_mismatch("slave1 cmd", cmd_rx1, row.cmd);
    n_tests++;
    if (errors != err0)
      n_bad++;
    $display("test %0d cmd %02h len %0d tag %02h: %0d errors", idx, row.cmd, row.len, tch,
             errors - err0);
  endtask

  task automatic check_direct();
    int   err0, k;
    logic csn_low;
    err0    = errors;
    csn_low = 1'b0;
    direct  = 1'b1;
    for (k = 0; k < 20 && !direct_en; k++)
      @(negedge clk);
    if (!direct_en)
      log_fault("direct_en did not rise between frames");
    sync = 1'b1;                                 // must be ignored under the grant
    @(negedge clk);
    sync = 1'b0;
    for (k = 0; k < 40; k++)
    begin
      if (!adxl_csn)
        csn_low = 1'b1;
      @(negedge clk);
    end
    if (csn_low)
      log_fault("sync during the direct grant started a frame");
    direct = 1'b0;
    for (k = 0; k < 20 && direct_en; k++)
      @(negedge clk);
    if (direct_en)
      log_fault("direct_en did not fall after direct dropped");
    n_tests++;
    if (errors != err0)
      n_bad++;
    $display("test direct grant: %0d errors", errors - err0);
  endtask

  always @(negedge clk)
  begin
    en_cnt = (en_cnt + 1) % 4;
    clk_en = en_cnt == 3;                        // one clk in four
  end

  // write port and grant monitor, outputs settled half a clock after the edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (wr || wr16 || x)
        check_write();
      if (direct_en && !adxl_csn)
        log_fault("direct_en high while adxl_csn is low");
      last_wr = wr;
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > max_cycles)
    begin
      $display("timeout: run still busy after %0d clocks", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  initial
  begin
    r             = $urandom(32'h5ace_5208);
    sclk_phase    = 1'b0;                        // SPI mode 0
    sclk_polarity = 1'b0;
    direct        = 1'b0;
    tag_pulse     = 1'b0;
    tag_en        = 1'b0;
    sync          = 1'b0;
    tag           = '0;
    cmd           = '0;
    len           = 4'd10;
    tx0           = '0;
    tx1           = '0;
    wait (rst_n);
    @(negedge clk);
    if (adxl_csn !== 1'b1)
      show_mismatch("adxl_csn", 8'(adxl_csn), 8'h01);
    if ({wr, wr16, x, direct_en} !== 4'b0000)
      show_mismatch("wr/wr16/x/direct_en", 8'({wr, wr16, x, direct_en}), 8'h00);
    n_tests++;
    if (errors != 0)
      n_bad++;
    $display("test reset values: %0d errors", errors);
    for (r = 0; r < n_rows; r++)
      run_frame(r, r == n_rows - 1);             // last frame also asks for the grant
    check_direct();
    $display("tests %0d, failing %0d, errors %0d", n_tests, n_bad, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// mode 0 SPI slave, takes the command on the first 8 SCLK rises
// data bits go out on each SCLK fall after the command byte
module spi_slave_model (
  input  logic         clk,
  input  logic         sclk,
  input  logic         csn,
  input  logic         mosi,
  input  logic [127:0] tx_bits, // bit 127 leaves first
  output logic         miso,
  output logic [7:0]   cmd_rx
);

  logic sclk_q;
  int   rises, falls;

  initial
  begin
    sclk_q = 1'b0;
    miso   = 1'b0;
    cmd_rx = '0;
    rises  = 0;
    falls  = 0;
  end

  always @(negedge clk)
  begin
    if (csn)
    begin
      rises = 0;                                 // deselected, restart bit counts
      falls = 0;
      miso  = 1'b0;
    end
    else if (sclk && !sclk_q && rises < 8)
    begin
      cmd_rx = {cmd_rx[6:0], mosi};
      rises++;
    end
    else if (!sclk && sclk_q)
    begin
      falls++;
      if (falls >= 8 && falls - 8 < 128)
        miso = tx_bits[127 - (falls - 8)];
    end
    sclk_q = sclk;
  end

endmodule

// ==== dv/tb_clk_gen.sv ====
// Clock and reset source for the frame reader testbench
// 40 ns clock, reset held low for the first 10 clocks
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1; // released away from the active edge
  end

  always #20 clk = ~clk;

endmodule

// ==== design/adxl_reader_top.sv ====
// Dual ADXL355 SPI frame reader, shared SCLK/CSn/MOSI, separate MISO
// ch0 bytes written live, ch1 bytes replayed on the same port after csn rises
`timescale 1ns/1ps

module adxl_reader_top #(
  parameter int tag_addr_bits = 11
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           clk_en,        // 1-clk pulse, SCLK is half its rate
  input  logic                           sclk_phase,
  input  logic                           sclk_polarity,
  input  logic                           direct,
  input  logic                           tag_pulse,
  input  logic                           tag_en,
  input  logic                           sync,
  input  logic [adxl_tag_pkg::tag_w-1:0] tag,
  input  logic [7:0]                     cmd,
  input  logic [3:0]                     len,
  output logic                           direct_en,
  output logic                           adxl_mosi,
  output logic                           adxl_sclk,
  output logic                           adxl_csn,
  input  logic                           adxl0_miso,
  input  logic                           adxl1_miso,
  output logic [7:0]                     wrdata,
  output logic                           wr,
  output logic                           wr16,
  output logic                           x
);

  spi_frame_if spi ();

  logic [adxl_tag_pkg::tag_w-1:0] tag_char;
  logic [7:0]                     byte0, byte1, rp_byte;
  logic                           wr0, wr16_0, rp_valid;

  adxl_seq_fsm u_seq (.clk, .rst_n, .sync, .direct, .clk_en, .cmd, .len, .direct_en,
                      .spi(spi.seq));

  adxl_bit_timer u_timer (.clk, .rst_n, .clk_en, .sclk_phase, .sclk_polarity,
                          .sclk(adxl_sclk), .spi(spi.timer));

  tag_fifo #(.tag_addr_bits(tag_addr_bits)) u_tag (.clk, .rst_n, .tag_en, .tag_pulse,
                                                   .tag, .tag_char, .spi(spi.data));

  adxl_spi_shifter u_shift (.clk, .rst_n, .clk_en, .miso0(adxl0_miso), .miso1(adxl1_miso),
                            .tag_char, .mosi(adxl_mosi), .byte0, .byte1, .wr0, .wr16_0,
                            .x, .spi(spi.data));

  chan1_replay_buf u_replay (.clk, .rst_n, .wr16_0, .byte1, .rp_valid, .rp_byte,
                             .spi(spi.replay));

  assign adxl_csn = spi.csn;
  assign wrdata   = rp_valid ? rp_byte : byte0; // replay never overlaps a live write
  assign wr       = wr0 | rp_valid;
  assign wr16     = wr16_0 | rp_valid;

endmodule

// ==== adxl_reader/chan1_replay_buf.sv ====
// Six-byte store for channel 1 wr16 bytes
// replays them back to back right after the frame ends
`timescale 1ns/1ps

module chan1_replay_buf (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr16_0,   // ch1 byte valid, same timing as ch0 wr16
  input  logic [7:0] byte1,
  output logic       rp_valid, // high for replay_len clks
  output logic [7:0] rp_byte,
  spi_frame_if.replay spi
);

  localparam int ptr_w = $clog2(adxl_frame_pkg::replay_len);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(adxl_frame_pkg::replay_len - 1);

  logic [7:0]       mem [adxl_frame_pkg::replay_len];
  logic [ptr_w-1:0] wptr, rptr;
  logic             cmd_load;
  logic             wr_ok;

  assign cmd_load = spi.index[adxl_frame_pkg::idx_w-1:1] == adxl_frame_pkg::cmd_load_step;
  assign wr_ok    = wr16_0 && wptr <= last_ptr; // extra bytes of long frames dropped
  assign rp_byte  = mem[rptr];

  always_ff @(posedge clk)
  begin
    if (wr_ok)
      mem[wptr] <= byte1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr     <= '0;
      rptr     <= '0;
      rp_valid <= 1'b0;
    end
    else
    begin
      if (cmd_load)
        wptr <= '0; // new frame
      else if (wr_ok)
        wptr <= wptr + 1'b1;
      if (spi.end_rise)
      begin
        rptr     <= '0;
        rp_valid <= 1'b1;
      end
      else if (rp_valid)
      begin
        if (rptr == last_ptr)
          rp_valid <= 1'b0;
        else
          rptr <= rptr + 1'b1;
      end
    end
  end

endmodule

// ==== adxl_reader/adxl_spi_shifter.sv ====
// MOSI/MISO shift registers for both accel channels
// byte capture with tag LSB insertion, wr/wr16/x strobes for channel 0
`timescale 1ns/1ps

module adxl_spi_shifter (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             clk_en,
  input  logic                             miso0,
  input  logic                             miso1,
  input  logic [adxl_tag_pkg::tag_w-1:0]   tag_char,
  output logic                             mosi,
  output logic [7:0]                       byte0,  // ch0 byte, valid with wr0
  output logic [7:0]                       byte1,  // ch1 byte, valid with wr16_0
  output logic                             wr0,    // every data byte
  output logic                             wr16_0, // 16-bit mode, skips every 3rd
  output logic                             x,      // first data byte of the frame
  spi_frame_if.data                        spi
);

  localparam int tag_i_w = $clog2(adxl_tag_pkg::tag_w);
  localparam logic [tag_i_w-1:0] tag_last = tag_i_w'(adxl_tag_pkg::tag_bits_per_chan);

  logic [adxl_frame_pkg::step_w-1:0] step;
  logic                              shift_en;
  logic                              cmd_load;
  logic                              byte_done;
  logic                              wr16_ok;
  logic [7:0]                        mosi_sr;
  logic [7:0]                        marker;     // one-hot, bit 7 on byte completion
  logic [7:0]                        sh0, sh1;
  logic [7:0]                        next0, next1;
  logic                              tag_on;     // toggles per wr16 byte
  logic [tag_i_w-1:0]                tag_i;      // tag bit position for ch0
  logic                              tag_live;
  logic                              tag_use;

  assign step      = spi.index[adxl_frame_pkg::idx_w-1:1];
  assign shift_en  = clk_en && !spi.index[0]; // even index, sample edge
  assign cmd_load  = step == adxl_frame_pkg::cmd_load_step;
  assign byte_done = marker[7] && spi.sclk_en && step != adxl_frame_pkg::wr_skip_step;
  assign wr16_ok   = step != adxl_frame_pkg::wr16_skip_steps[0] &&
                     step != adxl_frame_pkg::wr16_skip_steps[1] &&
                     step != adxl_frame_pkg::wr16_skip_steps[2];
  assign next0     = {sh0[6:0], miso0};
  assign next1     = {sh1[6:0], miso1};
  assign tag_live  = tag_on && tag_i < tag_last; // 3 bits per channel, then stop
  assign tag_use   = tag_live && wr16_ok;
  assign mosi      = mosi_sr[7];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mosi_sr <= '0;
      marker  <= 8'h01;
      wr0     <= 1'b0;
      wr16_0  <= 1'b0;
      x       <= 1'b0;
      tag_on  <= 1'b0;
      tag_i   <= '0;
    end
    else
    begin
      if (shift_en)
      begin
        mosi_sr <= cmd_load ? spi.cmd_byte : {mosi_sr[6:0], 1'b0}; // MSB first
        marker  <= cmd_load ? 8'h01 : {marker[6:0], marker[7]};
        wr0     <= byte_done;
        wr16_0  <= byte_done && wr16_ok;
        x       <= step == adxl_frame_pkg::x_step;
      end
      else
      begin
        wr0    <= 1'b0; // strobes last one clk
        wr16_0 <= 1'b0;
        x      <= 1'b0;
      end
      if (spi.start)
      begin
        tag_on <= 1'b0; // first wr16 byte untagged
        tag_i  <= '0;
      end
      else if (wr16_0)
      begin
        tag_on <= !tag_on;
        if (tag_live)
          tag_i <= tag_i + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (shift_en)
    begin
      sh0 <= next0;
      sh1 <= next1;
      if (marker[7])
      begin
        byte0 <= tag_use ? {next0[7:1], tag_char[tag_i]} : next0;
        byte1 <= tag_use ? {next1[7:1], tag_char[tag_i + tag_last]} : next1; // upper tag bits
      end
    end
  end

  // x marks the first write, never a lone strobe
  a_x_with_wr: assert property (@(posedge clk) disable iff (!rst_n)
    x |-> wr0 && wr16_0);

endmodule

// ==== adxl_reader/tag_fifo.sv ====
// Tag char FIFO, pushed by tag_en, popped once per frame on tag_latch
// a pending tag_pulse wins and yields "!", empty FIFO yields a space
`timescale 1ns/1ps

module tag_fifo #(
  parameter int tag_addr_bits = 11 // depth is 2**tag_addr_bits chars
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           tag_en,    // push one char
  input  logic                           tag_pulse, // request "!" on next frame
  input  logic [adxl_tag_pkg::tag_w-1:0] tag,
  output logic [adxl_tag_pkg::tag_w-1:0] tag_char,  // char embedded in this frame
  spi_frame_if.data                      spi
);

  localparam int depth = 2 ** tag_addr_bits;

  logic [adxl_tag_pkg::tag_w-1:0] mem [depth];
  logic [adxl_tag_pkg::tag_w-1:0] rd_q;       // registered head of FIFO
  logic [tag_addr_bits-1:0]       wptr, rptr;
  logic                           pulse_pend;
  logic                           empty;

  assign empty = wptr == rptr;

  always_ff @(posedge clk)
  begin
    if (tag_en)
      mem[wptr] <= tag; // no full check, wraps over oldest
    rd_q <= mem[rptr];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr       <= '0;
      rptr       <= '0;
      pulse_pend <= 1'b0;
      tag_char   <= adxl_tag_pkg::tag_idle_char;
    end
    else
    begin
      if (tag_en)
        wptr <= wptr + 1'b1;
      if (tag_pulse)
        pulse_pend <= 1'b1;
      else if (spi.tag_latch)
        pulse_pend <= 1'b0;
      if (spi.tag_latch)
      begin
        if (pulse_pend)
          tag_char <= adxl_tag_pkg::tag_pulse_char; // FIFO left untouched
        else if (empty)
          tag_char <= adxl_tag_pkg::tag_idle_char;
        else
        begin
          tag_char <= rd_q;
          rptr     <= rptr + 1'b1; // pop
        end
      end
    end
  end

endmodule

// ==== adxl_reader/adxl_bit_timer.sv ====
// Frame index counter, one step per clk_en, two steps per SCLK period
// decodes chip select, SCLK gate and end of frame from the index
`timescale 1ns/1ps

module adxl_bit_timer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clk_en,
  input  logic       sclk_phase,    // 0 for ADXL355
  input  logic       sclk_polarity, // 0 for ADXL355
  output logic       sclk,
  spi_frame_if.timer spi
);

  logic [adxl_frame_pkg::idx_w-1:0] end_idx;
  logic                             at_end_q;
  logic                             sclk_raw; // SCLK before polarity

  assign end_idx      = {spi.bytes_len, adxl_frame_pkg::end_nibble};
  assign spi.at_end   = spi.index == end_idx;
  assign spi.end_rise = spi.at_end && !at_end_q;
  assign sclk         = sclk_raw ^ sclk_polarity;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      spi.index   <= {adxl_frame_pkg::len_reset, adxl_frame_pkg::end_nibble}; // parked at end
      at_end_q    <= 1'b1;
      spi.csn     <= 1'b1;
      spi.sclk_en <= 1'b0;
      sclk_raw    <= 1'b0;
    end
    else
    begin
      at_end_q <= spi.at_end;
      if (spi.start)
        spi.index <= '0;
      else if (clk_en && !spi.at_end)
        spi.index <= spi.index + 1'b1;
      if (clk_en)
      begin
        spi.csn     <= spi.index == adxl_frame_pkg::csn_low_idx ? 1'b0 :
                       spi.index == {spi.bytes_len, adxl_frame_pkg::end_nibble - 4'd1} ? 1'b1 :
                       spi.csn;
        spi.sclk_en <= spi.index == adxl_frame_pkg::sclk_on_idx ? 1'b1 :
                       spi.index == {spi.bytes_len, adxl_frame_pkg::end_nibble - 4'd2} ? 1'b0 :
                       spi.sclk_en;
        sclk_raw    <= (spi.index[0] ^ sclk_phase) & spi.sclk_en;
      end
    end
  end

  // slave must be deselected whenever the frame is over
  a_csn_high_at_end: assert property (@(posedge clk) disable iff (!rst_n)
    spi.at_end |-> spi.csn);

endmodule

// ==== adxl_reader/adxl_seq_fsm.sv ====
// Frame sequencer, idle/active FSM with direct access grant
// latches cmd and len on sync and kicks off the bit timer
`timescale 1ns/1ps

module adxl_seq_fsm (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sync,    // frame request strobe
  input  logic       direct,  // direct access request
  input  logic       clk_en,
  input  logic [7:0] cmd,
  input  logic [3:0] len,
  output logic       direct_en,
  spi_frame_if.seq   spi
);

  typedef enum logic {st_idle, st_active} state_t;

  state_t state;
  logic   idle;

  assign idle      = (state == st_idle) && spi.at_end;
  assign spi.start = idle && sync && !direct_en; // sync ignored mid-frame or while granted

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= st_idle;
      direct_en     <= 1'b0;
      spi.cmd_byte  <= '0;
      spi.bytes_len <= adxl_frame_pkg::len_reset;
      spi.tag_latch <= 1'b0;
    end
    else
    begin
      spi.tag_latch <= spi.start; // tag fifo picks its char one clk after start
      case (state)
        st_idle:
        begin
          if (spi.start)
          begin
            state         <= st_active;
            spi.cmd_byte  <= cmd;
            spi.bytes_len <= len;
          end
          else if (clk_en && idle)
            direct_en <= direct; // grant only changes between frames
        end
        st_active:
        begin
          if (spi.at_end)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // a granted bus never has a frame running
  a_no_start_in_direct: assert property (@(posedge clk) disable iff (!rst_n)
    direct_en |-> spi.at_end);

endmodule

// ==== common/spi_frame_if.sv ====
// Frame control bundle between sequencer, bit timer and the data path blocks
// seq and timer drive it, data and replay only read
`timescale 1ns/1ps

interface spi_frame_if;

  logic                             start;     // 1-clk, frame begins
  logic [7:0]                       cmd_byte;  // latched SPI command
  logic [3:0]                       bytes_len; // latched length incl cmd byte
  logic                             tag_latch; // 1-clk, pick next tag char
  logic [adxl_frame_pkg::idx_w-1:0] index;     // running frame index
  logic                             at_end;    // index parked at end of frame
  logic                             end_rise;  // 1-clk, index just reached the end
  logic                             sclk_en;   // SCLK gate
  logic                             csn;       // chip select, active low

  modport seq    (output start, cmd_byte, bytes_len, tag_latch, input at_end);
  modport timer  (input start, bytes_len, output index, at_end, end_rise, sclk_en, csn);
  modport data   (input start, cmd_byte, bytes_len, tag_latch, index, at_end, end_rise,
                  sclk_en, csn);
  modport replay (input index, end_rise);

endinterface

// ==== common/adxl_tag_pkg.sv ====
// Tag character constants, 6-bit chars spread over the accel byte LSBs
// shared by the tag FIFO and the SPI shifter
package adxl_tag_pkg;

  localparam int tag_w = 6; // tag char width

  localparam logic [tag_w-1:0] tag_pulse_char = 6'h21; // "!" inserted by tag_pulse
  localparam logic [tag_w-1:0] tag_idle_char  = 6'h20; // space when FIFO is empty

  // ch0 carries bits 0..2, ch1 carries bits 3..5
  localparam int tag_bits_per_chan = 3;

endpackage

// ==== common/adxl_frame_pkg.sv ====
// SPI frame timing constants for the ADXL355 frame reader
// index layout is {byte count, half-bit step nibble}, step = index >> 1
package adxl_frame_pkg;

  localparam int idx_w  = 8;         // frame index width
  localparam int step_w = idx_w - 1; // half-index width, one step per SCLK period

  localparam logic [3:0] end_nibble = 4'h6;  // low nibble of the end-of-frame index
  localparam logic [3:0] len_reset  = 4'd10; // frame length after reset, cmd byte included

  localparam logic [idx_w-1:0] csn_low_idx = idx_w'(1); // chip select falls here
  localparam logic [idx_w-1:0] sclk_on_idx = idx_w'(3); // SCLK starts toggling here

  localparam logic [step_w-1:0] cmd_load_step = step_w'(2);  // cmd byte enters MOSI shifter
  localparam logic [step_w-1:0] wr_skip_step  = step_w'(10); // cmd byte completes, no write
  localparam logic [step_w-1:0] x_step        = step_w'(18); // first data byte, x axis

  // every third data byte is the low accel byte of a 20-bit sample, dropped in 16-bit mode
  localparam logic [2:0][step_w-1:0] wr16_skip_steps = {
    step_w'(82),
    step_w'(58),
    step_w'(34)
  };

  localparam int replay_len = 6; // channel 1 bytes kept per frame

endpackage
